// ==== project.f ====
source/priv_pkg.sv
source/check_pkg.sv
source/insn_classifier.sv
source/mode_tracker.sv
source/rule_checker.sv
source/check_regs.sv
source/umode_monitor_top.sv
test/tb_clock_gen.sv
test/tb_umode_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_umode_monitor -f project.f \
  -Mdir "$BUILD_DIR" -o sim_exe
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/sim_exe" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== source/check_pkg.sv ====
//////////////////////////////////////////////////
// monitor-side types for rule indices and vectors,
// decoded instruction info and the config register map
//////////////////////////////////////////////////

package check_pkg;

  // bit index of each rule in a rule vector
  typedef enum logic [3:0] {
    RULE_MODE_SUPPORTED = 4'd0,
    RULE_MSCRATCH_U     = 4'd1,
    RULE_MPP_VALUE      = 4'd2,
    RULE_TRAP_TO_M      = 4'd3,
    RULE_MRET_TO_MPP    = 4'd4,
    RULE_WFI_TW         = 4'd5,
    RULE_ECALL_U        = 4'd6,
    RULE_EBREAK_U       = 4'd7,
    RULE_CSR_PRIV       = 4'd8,
    RULE_DMODE_M        = 4'd9,
    RULE_UMODE_MPRV     = 4'd10
  } rule_e;

  localparam int NUM_RULES = 11;

  typedef logic [NUM_RULES-1:0] rule_vec_t;

  typedef enum logic [2:0] {
    INSN_OTHER,
    INSN_MRET,
    INSN_WFI,
    INSN_ECALL,
    INSN_EBREAK,
    INSN_URET,
    INSN_CSR
  } insn_class_e;

  typedef struct packed {
    insn_class_e cls;
    logic [11:0] csr_addr;
  } insn_info_t;

  typedef enum logic [1:0] {
    CFG_ENABLE = 2'd0,
    CFG_STATUS = 2'd1,
    CFG_COUNT  = 2'd2
  } cfg_addr_e;

endpackage

// ==== source/check_regs.sv ====
//////////////////////////////////////////////////
// config and status block: rule enable mask,
// sticky status, saturating violation counter and
// the error level; read data is combinational
//////////////////////////////////////////////////

`timescale 1ns/10ps

module check_regs
  import check_pkg::*;
#(
  parameter int COUNT_W = 16
) (
  input  logic        clk_i,
  input  logic        rst_n,
  input  logic        cfg_we,
  input  cfg_addr_e   cfg_addr,
  input  logic [31:0] cfg_wdata,
  output logic [31:0] cfg_rdata,
  input  rule_vec_t   violation,
  output rule_vec_t   enable,
  output logic        error
);

  rule_vec_t          status_q;
  rule_vec_t          status_d;
  rule_vec_t          status_clr;
  logic [COUNT_W-1:0] count_q;
  logic               count_max;

  always_comb begin
    // a new violation wins over the write-1-to-clear
    status_clr = (cfg_we && (cfg_addr == CFG_STATUS)) ? cfg_wdata[NUM_RULES-1:0] : '0;
    status_d   = (status_q & ~status_clr) | violation;
    count_max  = (count_q == {COUNT_W{1'b1}});
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      enable   <= '1;
      status_q <= '0;
      count_q  <= '0;
      error    <= 1'b0;
    end else begin
      status_q <= status_d;
      error    <= |status_d;
      if (cfg_we && (cfg_addr == CFG_ENABLE)) begin
        enable <= cfg_wdata[NUM_RULES-1:0];
      end
      if (cfg_we && (cfg_addr == CFG_COUNT)) begin
        count_q <= '0;
      end else if ((violation != '0) && !count_max) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      CFG_ENABLE: cfg_rdata = 32'(enable);
      CFG_STATUS: cfg_rdata = 32'(status_q);
      CFG_COUNT:  cfg_rdata = 32'(count_q);
      default:    cfg_rdata = 32'h0;
    endcase
  end

endmodule

// ==== source/insn_classifier.sv ====
//////////////////////////////////////////////////
// combinational decode of the retired instruction
// into a class and a CSR address for the checker
//////////////////////////////////////////////////

`timescale 1ns/10ps

module insn_classifier
  import priv_pkg::*;
  import check_pkg::*;
(
  input  retire_rec_t retire,
  output insn_info_t  info
);

  logic       revoked;
  logic [2:0] funct3;
  logic       is_csr;

  always_comb begin
    // fetch faults never executed, so they have no class
    revoked = retire.trap_exception &&
              (retire.exc_cause inside {EXC_INSTR_FAULT, EXC_INSTR_BUS_FAULT});
    funct3  = retire.insn[14:12];
    is_csr  = (retire.insn[6:0] == SYSTEM_OPCODE) &&
              (funct3 != 3'd0) && (funct3 != 3'd4);
  end

  always_comb begin
    info.cls      = INSN_OTHER;
    info.csr_addr = 12'h000;
    if (retire.valid && !revoked) begin
      if (retire.insn == MRET_INSN) begin
        info.cls = INSN_MRET;
      end else if (retire.insn == WFI_INSN) begin
        info.cls = INSN_WFI;
      end else if (retire.insn == ECALL_INSN) begin
        info.cls = INSN_ECALL;
      end else if (retire.insn == EBREAK_INSN) begin
        info.cls = INSN_EBREAK;
      end else if (retire.insn == URET_INSN) begin
        info.cls = INSN_URET;
      end else if (is_csr) begin
        info.cls      = INSN_CSR;
        info.csr_addr = retire.insn[31:20];
      end
    end
  end

endmodule

// ==== source/mode_tracker.sv ====
//////////////////////////////////////////////////
// history of the last valid retirement, used by
// the checker for rules spanning two retirements
//////////////////////////////////////////////////

`timescale 1ns/10ps

module mode_tracker
  import priv_pkg::*;
  import check_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n,
  input  retire_rec_t retire,
  input  insn_info_t  info,
  output logic        prev_trap,
  output logic        prev_mret_m,
  output logic        prev_ebreaku,
  output priv_mode_e  prev_mret_mpp
);

  logic mret_m;
  logic ebreaku;

  always_comb begin
    // untrapped mret from M mode outside debug
    mret_m  = (info.cls == INSN_MRET) && (retire.mode == MODE_M) &&
              !retire.trap_exception && !retire.dbg_mode;
    ebreaku = (info.cls == INSN_EBREAK) && (retire.mode == MODE_U) &&
              retire.dcsr_rdata[EBREAKU_POS];
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      prev_trap     <= 1'b0;
      prev_mret_m   <= 1'b0;
      prev_ebreaku  <= 1'b0;
      prev_mret_mpp <= MODE_U;
    end else if (retire.valid) begin
      prev_trap     <= retire.trap_exception;
      prev_mret_m   <= mret_m;
      prev_ebreaku  <= ebreaku;
      // MPP as read by the mret
      prev_mret_mpp <= priv_mode_e'(retire.mstatus_rdata[MPP_POS +: 2]);
    end
  end

endmodule

// ==== source/priv_pkg.sv ====
//////////////////////////////////////////////////
// RISC-V privilege definitions shared by the
// monitor, with modes, CSR field positions, exception
// causes, fixed encodings and the retirement record
//////////////////////////////////////////////////

package priv_pkg;

  // MODE_S only names an illegal value on this two-mode core
  typedef enum logic [1:0] {
    MODE_U = 2'b00,
    MODE_S = 2'b01,
    MODE_M = 2'b11
  } priv_mode_e;

  // mstatus fields
  localparam int MPP_POS  = 11;
  localparam int MPRV_POS = 17;
  localparam int TW_POS   = 21;

  // dcsr fields
  localparam int EBREAKU_POS = 12;

  // exception causes as seen on the trace
  localparam logic [5:0] EXC_INSTR_FAULT     = 6'd1;
  localparam logic [5:0] EXC_ILLEGAL_INSN    = 6'd2;
  localparam logic [5:0] EXC_BREAKPOINT      = 6'd3;
  localparam logic [5:0] EXC_ECALL_U         = 6'd8;
  localparam logic [5:0] EXC_INSTR_BUS_FAULT = 6'd24;

  localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;

  // fixed system instruction encodings
  localparam logic [31:0] MRET_INSN   = 32'h3020_0073;
  localparam logic [31:0] WFI_INSN    = 32'h1050_0073;
  localparam logic [31:0] ECALL_INSN  = 32'h0000_0073;
  localparam logic [31:0] EBREAK_INSN = 32'h0010_0073;
  localparam logic [31:0] URET_INSN   = 32'h0020_0073;

  // one retired instruction from the trace port
  typedef struct packed {
    logic        valid;
    priv_mode_e  mode;
    logic [31:0] insn;
    logic        trap_exception;
    logic [5:0]  exc_cause;
    logic        dbg_mode;
    logic [31:0] mstatus_rdata;
    logic [31:0] mstatus_wdata;
    logic [31:0] mstatus_wmask;
    logic [31:0] mscratch_wmask;
    logic [31:0] dcsr_rdata;
  } retire_rec_t;

endpackage

// ==== source/rule_checker.sv ====
//////////////////////////////////////////////////
// evaluates each privilege rule on a retirement,
// masks with the enable vector and registers the
// result as a one-cycle violation pulse
//////////////////////////////////////////////////

`timescale 1ns/10ps

module rule_checker
  import priv_pkg::*;
  import check_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n,
  input  retire_rec_t retire,
  input  insn_info_t  info,
  input  logic        prev_trap,
  input  logic        prev_mret_m,
  input  logic        prev_ebreaku,
  input  priv_mode_e  prev_mret_mpp,
  input  rule_vec_t   enable,
  output rule_vec_t   violation
);

  logic [31:0] mstatus_post;
  logic [1:0]  mpp_post;
  logic        is_u;
  logic        not_m;
  logic        illegal_exc;
  logic        bkpt_exc;
  logic        ecall_exc;
  logic        ebreak_u_now;
  rule_vec_t   viol_d;

  always_comb begin
    // mstatus value after the instruction
    mstatus_post = (retire.mstatus_wdata & retire.mstatus_wmask) |
                   (retire.mstatus_rdata & ~retire.mstatus_wmask);
    mpp_post     = mstatus_post[MPP_POS +: 2];

    is_u  = (retire.mode == MODE_U);
    not_m = (retire.mode != MODE_M);

    illegal_exc = retire.trap_exception && (retire.exc_cause == EXC_ILLEGAL_INSN);
    bkpt_exc    = retire.trap_exception && (retire.exc_cause == EXC_BREAKPOINT);
    ecall_exc   = retire.trap_exception && (retire.exc_cause == EXC_ECALL_U);

    // without EBREAKU the ebreak must raise a breakpoint
    ebreak_u_now = (info.cls == INSN_EBREAK) && is_u &&
                   !retire.dcsr_rdata[EBREAKU_POS] && !bkpt_exc;
  end

  always_comb begin
    viol_d = '0;
    if (retire.valid) begin
      viol_d[RULE_MODE_SUPPORTED] = !(retire.mode inside {MODE_U, MODE_M});
      viol_d[RULE_MSCRATCH_U]     = is_u && (retire.mscratch_wmask != 32'h0);
      viol_d[RULE_MPP_VALUE]      = !(mpp_post inside {MODE_U, MODE_M});
      viol_d[RULE_TRAP_TO_M]      = prev_trap && not_m;
      viol_d[RULE_MRET_TO_MPP]    = prev_mret_m && (retire.mode != prev_mret_mpp);

      // TW set means wfi in U mode must be illegal, clear means it must not be
      viol_d[RULE_WFI_TW]   = (info.cls == INSN_WFI) && is_u &&
                              (retire.mstatus_rdata[TW_POS] != illegal_exc);
      viol_d[RULE_ECALL_U]  = (info.cls == INSN_ECALL) && is_u && !ecall_exc;
      viol_d[RULE_EBREAK_U] = ebreak_u_now || (prev_ebreaku && !retire.dbg_mode);

      // csr address bits 9:8 hold the lowest privilege allowed
      viol_d[RULE_CSR_PRIV] = (info.cls == INSN_CSR) && is_u &&
                              (info.csr_addr[9:8] != 2'b00) && !illegal_exc;

      viol_d[RULE_DMODE_M]    = retire.dbg_mode && not_m;
      viol_d[RULE_UMODE_MPRV] = is_u && retire.mstatus_rdata[MPRV_POS];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      violation <= '0;
    end else begin
      violation <= viol_d & enable;
    end
  end

endmodule

// ==== source/umode_monitor_top.sv ====
//////////////////////////////////////////////////
// user-mode privilege monitor top level; takes the
// retirement trace and a config write strobe
//////////////////////////////////////////////////

`timescale 1ns/10ps

module umode_monitor_top
  import priv_pkg::*;
  import check_pkg::*;
#(
  parameter int COUNT_W = 16
) (
  input  logic        clk_i,
  input  logic        rst_n,
  input  retire_rec_t retire,
  input  logic        cfg_we,
  input  cfg_addr_e   cfg_addr,
  input  logic [31:0] cfg_wdata,
  output logic [31:0] cfg_rdata,
  output rule_vec_t   violation,
  output logic        error
);

  insn_info_t info;
  logic       prev_trap;
  logic       prev_mret_m;
  logic       prev_ebreaku;
  priv_mode_e prev_mret_mpp;
  rule_vec_t  enable;

  insn_classifier i_classifier (
    .retire (retire),
    .info   (info)
  );

  mode_tracker i_tracker (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .retire        (retire),
    .info          (info),
    .prev_trap     (prev_trap),
    .prev_mret_m   (prev_mret_m),
    .prev_ebreaku  (prev_ebreaku),
    .prev_mret_mpp (prev_mret_mpp)
  );

  rule_checker i_checker (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .retire        (retire),
    .info          (info),
    .prev_trap     (prev_trap),
    .prev_mret_m   (prev_mret_m),
    .prev_ebreaku  (prev_ebreaku),
    .prev_mret_mpp (prev_mret_mpp),
    .enable        (enable),
    .violation     (violation)
  );

  check_regs #(
    .COUNT_W (COUNT_W)
  ) i_regs (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .violation (violation),
    .enable    (enable),
    .error     (error)
  );

endmodule

// ==== test/tb_clock_gen.sv ====
//////////////////////////////////////////////////
// testbench clock and reset source; free-running
// clock, reset held low for a few cycles at start
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_i,
  output logic rst_n
);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD_NS / 2) clk_i = ~clk_i;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== test/tb_umode_monitor.sv ====
//////////////////////////////////////////////////
// directed testbench for the user-mode privilege
// monitor; each test task drives retirements or
// config accesses and checks the DUT response
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_umode_monitor
  import priv_pkg::*;
  import check_pkg::*;
();

  localparam int CLK_PERIOD_NS   = 8;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  // one bit per rule, zero-extended to a register word
  localparam logic [31:0] ALL_RULES = (32'd1 << NUM_RULES) - 32'd1;

  logic        clk_i;
  logic        rst_n;
  retire_rec_t retire;
  logic        cfg_we;
  cfg_addr_e   cfg_addr;
  logic [31:0] cfg_wdata;
  logic [31:0] cfg_rdata;
  rule_vec_t   violation;
  logic        error;

  logic [31:0] lcg_state;
  string       test_name;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (3)
  ) i_clock_gen (
    .clk_i (clk_i),
    .rst_n (rst_n)
  );

  umode_monitor_top #(
    .COUNT_W (16)
  ) i_dut (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .retire    (retire),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .violation (violation),
    .error     (error)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic rule_vec_t rule_bit(rule_e r);
    rule_vec_t v;
    v    = '0;
    v[r] = 1'b1;
    return v;
  endfunction

  // legal retirement of a random OP-IMM instruction
  function automatic retire_rec_t legal_rec(priv_mode_e mode);
    retire_rec_t r;
    logic [31:0] pick;
    r               = '0;
    pick            = lcg_next();
    r.valid         = 1'b1;
    r.mode          = mode;
    r.insn          = lcg_next();
    r.insn[6:0]     = 7'b0010011;
    r.mstatus_rdata = lcg_next();
    r.mstatus_rdata[MPP_POS +: 2] = pick[9] ? 2'b11 : 2'b00;
    r.mstatus_rdata[MPRV_POS]     = 1'b0;
    r.mstatus_wdata = lcg_next();
    r.dcsr_rdata    = lcg_next();
    if (mode == MODE_M) begin
      r.mscratch_wmask = lcg_next();
    end
    return r;
  endfunction

  task automatic fail_stop();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rules(string what, rule_vec_t exp, rule_vec_t act);
    if (act !== exp) begin
      $display("CHECK FAILED [%s] %s: expected %b, actual %b", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_word(string what, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_level(string what, logic exp, logic act);
    if (act !== exp) begin
      $display("CHECK FAILED [%s] %s: expected %b, actual %b", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  // one retirement, violation checked one cycle later
  task automatic retire_one(retire_rec_t rec, rule_vec_t exp, string what);
    @(posedge clk_i);
    #1;
    retire = rec;
    @(posedge clk_i);
    #1;
    retire.valid = 1'b0;
    check_rules(what, exp, violation);
  endtask

  task automatic idle_cycles(int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic cfg_write(cfg_addr_e addr, logic [31:0] data);
    @(posedge clk_i);
    #1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk_i);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic cfg_read(cfg_addr_e addr, output logic [31:0] data);
    @(posedge clk_i);
    #1;
    cfg_addr = addr;
    #1;
    data = cfg_rdata;
  endtask

  task automatic test_reset_values();
    logic [31:0] rd;
    test_name = "reset_values";
    cfg_read(CFG_ENABLE, rd);
    check_word("enable after reset", ALL_RULES, rd);
    cfg_read(CFG_STATUS, rd);
    check_word("status after reset", 32'h0, rd);
    cfg_read(CFG_COUNT, rd);
    check_word("count after reset", 32'h0, rd);
    check_level("error after reset", 1'b0, error);
    repeat (4) begin
      retire_one(legal_rec(MODE_M), '0, "legal M retirement");
      retire_one(legal_rec(MODE_U), '0, "legal U retirement");
    end
  endtask

  task automatic test_single_rules();
    retire_rec_t r;
    test_name = "single_rules";
    r = legal_rec(MODE_M);
    r.mode = MODE_S;
    retire_one(r, rule_bit(RULE_MODE_SUPPORTED), "mode S");
    r = legal_rec(MODE_U);
    r.mscratch_wmask = lcg_next() | 32'h1;
    retire_one(r, rule_bit(RULE_MSCRATCH_U), "mscratch write in U");
    r = legal_rec(MODE_M);
    r.mstatus_wmask[MPP_POS +: 2] = 2'b11;
    r.mstatus_wdata[MPP_POS +: 2] = 2'b01;
    retire_one(r, rule_bit(RULE_MPP_VALUE), "MPP written to S");
    r.mstatus_wdata[MPP_POS +: 2] = 2'b00;
    retire_one(r, '0, "MPP written to U");

    r = legal_rec(MODE_U);
    r.insn = WFI_INSN;
    r.mstatus_rdata[TW_POS] = 1'b1;
    retire_one(r, rule_bit(RULE_WFI_TW), "wfi TW=1 without exception");
    r.mstatus_rdata[TW_POS] = 1'b0;
    retire_one(r, '0, "wfi TW=0");
    r.mstatus_rdata[TW_POS] = 1'b1;
    r.trap_exception = 1'b1;
    r.exc_cause = EXC_ILLEGAL_INSN;
    retire_one(r, '0, "wfi TW=1 illegal");
    retire_one(legal_rec(MODE_M), '0, "handler after wfi trap");

    r = legal_rec(MODE_U);
    r.insn = ECALL_INSN;
    r.trap_exception = 1'b1;
    r.exc_cause = EXC_ILLEGAL_INSN;
    retire_one(r, rule_bit(RULE_ECALL_U), "ecall wrong cause");
    retire_one(legal_rec(MODE_M), '0, "handler after ecall");
    r.exc_cause = EXC_ECALL_U;
    retire_one(r, '0, "ecall user cause");
    retire_one(legal_rec(MODE_M), '0, "handler after ecall");

    r = legal_rec(MODE_U);
    r.insn = EBREAK_INSN;
    r.dcsr_rdata[EBREAKU_POS] = 1'b0;
    retire_one(r, rule_bit(RULE_EBREAK_U), "ebreak without breakpoint");
    r.trap_exception = 1'b1;
    r.exc_cause = EXC_BREAKPOINT;
    retire_one(r, '0, "ebreak with breakpoint");
    retire_one(legal_rec(MODE_M), '0, "handler after ebreak");

    // csrrw x0, mstatus, x0 from U mode
    r = legal_rec(MODE_U);
    r.insn = 32'h3000_1073;
    retire_one(r, rule_bit(RULE_CSR_PRIV), "U access to mstatus");
    r.trap_exception = 1'b1;
    r.exc_cause = EXC_ILLEGAL_INSN;
    retire_one(r, '0, "U access to mstatus trapped");
    retire_one(legal_rec(MODE_M), '0, "handler after csr trap");
    r = legal_rec(MODE_U);
    r.insn = 32'h0010_2073;
    retire_one(r, '0, "U access to user csr");

    r = legal_rec(MODE_U);
    r.dbg_mode = 1'b1;
    retire_one(r, rule_bit(RULE_DMODE_M), "debug in U mode");
    r = legal_rec(MODE_U);
    r.mstatus_rdata[MPRV_POS] = 1'b1;
    retire_one(r, rule_bit(RULE_UMODE_MPRV), "MPRV set in U");
  endtask

  task automatic test_two_retirements();
    retire_rec_t r;
    test_name = "two_retirements";
    r = legal_rec(MODE_M);
    r.trap_exception = 1'b1;
    r.exc_cause = EXC_ILLEGAL_INSN;
    retire_one(r, '0, "trapping retirement");
    idle_cycles(3);
    retire_one(legal_rec(MODE_U), rule_bit(RULE_TRAP_TO_M), "U after trap");
    retire_one(r, '0, "trapping retirement");
    retire_one(legal_rec(MODE_M), '0, "M after trap");

    r = legal_rec(MODE_M);
    r.insn = MRET_INSN;
    r.mstatus_rdata[MPP_POS +: 2] = 2'b00;
    retire_one(r, '0, "mret to U");
    retire_one(legal_rec(MODE_M), rule_bit(RULE_MRET_TO_MPP), "M after mret to U");
    retire_one(r, '0, "mret to U");
    retire_one(legal_rec(MODE_U), '0, "U after mret to U");

    r = legal_rec(MODE_U);
    r.insn = EBREAK_INSN;
    r.dcsr_rdata[EBREAKU_POS] = 1'b1;
    retire_one(r, '0, "ebreak into debug");
    retire_one(legal_rec(MODE_M), rule_bit(RULE_EBREAK_U), "no debug after ebreak");
    retire_one(r, '0, "ebreak into debug");
    r = legal_rec(MODE_M);
    r.dbg_mode = 1'b1;
    retire_one(r, '0, "debug M after ebreak");
  endtask

  task automatic test_enable_mask();
    retire_rec_t r;
    logic [31:0] rd;
    logic [31:0] mask;
    test_name = "enable_mask";
    mask = ALL_RULES & ~32'(rule_bit(RULE_DMODE_M));
    // start from an empty status so a masked rule bit would show
    cfg_write(CFG_STATUS, ALL_RULES);
    cfg_write(CFG_ENABLE, mask);
    cfg_read(CFG_ENABLE, rd);
    check_word("enable readback", mask, rd);
    r = legal_rec(MODE_U);
    r.dbg_mode = 1'b1;
    retire_one(r, '0, "masked debug in U");
    cfg_read(CFG_STATUS, rd);
    check_word("status unchanged", 32'h0, rd);
    r = legal_rec(MODE_U);
    r.mscratch_wmask = 32'h8000_0000;
    retire_one(r, rule_bit(RULE_MSCRATCH_U), "unmasked rule");
    cfg_write(CFG_ENABLE, ALL_RULES);
  endtask

  task automatic test_status_counter();
    retire_rec_t r;
    rule_vec_t   exp;
    rule_vec_t   seen;
    logic [31:0] rd;
    test_name = "status_counter";
    cfg_write(CFG_STATUS, ALL_RULES);
    cfg_write(CFG_COUNT, 32'h0);
    cfg_read(CFG_STATUS, rd);
    check_word("status cleared", 32'h0, rd);
    cfg_read(CFG_COUNT, rd);
    check_word("count cleared", 32'h0, rd);
    check_level("error cleared", 1'b0, error);

    r = legal_rec(MODE_U);
    r.mscratch_wmask = lcg_next() | 32'h4;
    exp = rule_bit(RULE_MSCRATCH_U);
    retire_one(r, exp, "first violation");
    seen = exp;
    check_level("error one cycle on", 1'b0, error);
    @(posedge clk_i);
    #1;
    check_level("error two cycles on", 1'b1, error);

    r = legal_rec(MODE_U);
    r.mstatus_rdata[MPRV_POS] = 1'b1;
    exp = rule_bit(RULE_UMODE_MPRV);
    retire_one(r, exp, "second violation");
    seen = seen | exp;
    r = legal_rec(MODE_M);
    r.mode = MODE_S;
    exp = rule_bit(RULE_MODE_SUPPORTED);
    retire_one(r, exp, "third violation");
    seen = seen | exp;
    // two rules broken by a single retirement
    r = legal_rec(MODE_U);
    r.dbg_mode = 1'b1;
    r.mstatus_rdata[MPRV_POS] = 1'b1;
    exp = rule_bit(RULE_DMODE_M) | rule_bit(RULE_UMODE_MPRV);
    retire_one(r, exp, "fourth violation");
    seen = seen | exp;

    cfg_read(CFG_STATUS, rd);
    check_word("sticky status", 32'(seen), rd);
    cfg_read(CFG_COUNT, rd);
    check_word("violation count", 32'd4, rd);

    cfg_write(CFG_STATUS, 32'(rule_bit(RULE_MSCRATCH_U)));
    cfg_read(CFG_STATUS, rd);
    check_word("status partly cleared", 32'(seen & ~rule_bit(RULE_MSCRATCH_U)), rd);
    check_level("error still set", 1'b1, error);
    cfg_write(CFG_STATUS, 32'(seen));
    cfg_read(CFG_STATUS, rd);
    check_word("status fully cleared", 32'h0, rd);
    check_level("error fallen", 1'b0, error);
    cfg_write(CFG_COUNT, 32'hffff_ffff);
    cfg_read(CFG_COUNT, rd);
    check_word("count cleared by write", 32'h0, rd);
  endtask

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD_NS);
    $display("timeout: the tests did not finish within the watchdog limit");
    fail_stop();
  end

  initial begin
    retire    = '0;
    cfg_we    = 1'b0;
    cfg_addr  = CFG_ENABLE;
    cfg_wdata = 32'h0;
    lcg_state = 32'he0d7_2051;
    test_name = "startup";
    @(posedge rst_n);
    test_reset_values();
    test_single_rules();
    test_two_retirements();
    test_enable_mask();
    test_status_counter();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
